// ==== rtl/rv32i_isa_pkg.sv ====
package rv32i_isa_pkg;

  typedef logic [6:0] opcode_t;
  typedef logic [2:0] funct3_t;
  typedef logic [3:0] alu_ctrl_t;

  // ====================
  // major opcodes
  // ====================
  localparam opcode_t OPC_OP     = 7'b0110011;
  localparam opcode_t OPC_OP_IMM = 7'b0010011;
  localparam opcode_t OPC_LUI    = 7'b0110111;
  localparam opcode_t OPC_AUIPC  = 7'b0010111;
  localparam opcode_t OPC_JAL    = 7'b1101111;
  localparam opcode_t OPC_JALR   = 7'b1100111;
  localparam opcode_t OPC_BRANCH = 7'b1100011;

  // branch conditions
  localparam funct3_t F3_BEQ  = 3'b000;
  localparam funct3_t F3_BNE  = 3'b001;
  localparam funct3_t F3_BLT  = 3'b100;
  localparam funct3_t F3_BGE  = 3'b101;
  localparam funct3_t F3_BLTU = 3'b110;
  localparam funct3_t F3_BGEU = 3'b111;

  // right shifts, bit 30 picks arithmetic
  localparam funct3_t F3_SR = 3'b101;

  // ====================
  // alu operations
  // ====================
  // encoded as {instr[30], funct3} of the register form
  localparam alu_ctrl_t ALU_ADD  = 4'b0000;
  localparam alu_ctrl_t ALU_SUB  = 4'b1000;
  localparam alu_ctrl_t ALU_SLL  = 4'b0001;
  localparam alu_ctrl_t ALU_SLT  = 4'b0010;
  localparam alu_ctrl_t ALU_SLTU = 4'b0011;
  localparam alu_ctrl_t ALU_XOR  = 4'b0100;
  localparam alu_ctrl_t ALU_SRL  = 4'b0101;
  localparam alu_ctrl_t ALU_SRA  = 4'b1101;
  localparam alu_ctrl_t ALU_OR   = 4'b0110;
  localparam alu_ctrl_t ALU_AND  = 4'b0111;

endpackage

// ==== rtl/exec_types_pkg.sv ====
package exec_types_pkg;

  // datapath widths
  localparam int unsigned XLEN       = 32;
  localparam int unsigned REG_ADDR_W = 5;
  localparam int unsigned INSTR_W    = 32;

  typedef logic [XLEN-1:0]       xlen_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [INSTR_W-1:0]    instr_t;

  // ====================
  // pipeline constants
  // ====================
  // link address offset for jal and jalr
  localparam xlen_t PC_STEP = xlen_t'(4);

endpackage

// ==== rtl/exec_bundle_if.sv ====
`timescale 1ns/1ps

interface exec_bundle_if;
  import exec_types_pkg::*;
  import rv32i_isa_pkg::*;

  // one decoded instruction, replaced every cycle
  logic      valid;
  xlen_t     pc;
  xlen_t     rs1_val;
  xlen_t     rs2_val;
  xlen_t     imm;
  alu_ctrl_t alu_ctrl;
  logic      use_imm;
  logic      use_pc;
  reg_addr_t rd;
  logic      rd_we;
  logic      res_sel_link;
  logic      res_sel_imm;
  logic      is_branch;
  logic      is_jal;
  logic      is_jalr;
  funct3_t   funct3;

  modport producer (
    output valid, pc, rs1_val, rs2_val, imm, alu_ctrl, use_imm, use_pc,
    output rd, rd_we, res_sel_link, res_sel_imm, is_branch, is_jal, is_jalr, funct3
  );

  modport consumer (
    input valid, pc, rs1_val, rs2_val, imm, alu_ctrl, use_imm, use_pc,
    input rd, rd_we, res_sel_link, res_sel_imm, is_branch, is_jal, is_jalr, funct3
  );

endinterface

// ==== rtl/instr_decode.sv ====
`timescale 1ns/1ps

module instr_decode (
  input  logic                   clk,
  input  logic                   arst_n_i,
  input  logic                   valid_i,
  input  exec_types_pkg::instr_t instr_i,
  input  exec_types_pkg::xlen_t  pc_i,
  input  exec_types_pkg::xlen_t  rs1_data_i,
  input  exec_types_pkg::xlen_t  rs2_data_i,
  exec_bundle_if.producer        bundle
);
  import exec_types_pkg::*;
  import rv32i_isa_pkg::*;

  opcode_t   opcode;
  reg_addr_t rd;
  funct3_t   funct3;
  logic      funct7_5;
  xlen_t     imm_i, imm_u, imm_j, imm_b, imm;
  alu_ctrl_t alu_ctrl;
  logic      use_imm, use_pc, writes, br_ok;

  // ====================
  // field extraction
  // ====================
  assign opcode   = instr_i[6:0];
  assign rd       = instr_i[11:7];
  assign funct3   = instr_i[14:12];
  assign funct7_5 = instr_i[30];

  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};

  // only the six defined conditions count as branches
  assign br_ok = funct3 inside {F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};

  // ====================
  // control decode
  // ====================
  always_comb begin
    imm      = imm_i;
    alu_ctrl = ALU_ADD;
    use_imm  = 1'b0;
    use_pc   = 1'b0;
    writes   = 1'b1;
    case (opcode)
      OPC_OP: alu_ctrl = alu_ctrl_t'({funct7_5, funct3});
      OPC_OP_IMM: begin
        use_imm  = 1'b1;
        // bit 30 is part of the immediate except for srai
        alu_ctrl = alu_ctrl_t'({funct7_5 & (funct3 == F3_SR), funct3});
      end
      OPC_LUI: imm = imm_u;
      OPC_AUIPC: begin
        imm     = imm_u;
        use_pc  = 1'b1;
        use_imm = 1'b1;
      end
      OPC_JAL: imm = imm_j;
      OPC_JALR: imm = imm_i;
      OPC_BRANCH: begin
        imm    = imm_b;
        writes = 1'b0;
      end
      default: writes = 1'b0;
    endcase
  end

  // decode to execute register, control part
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      bundle.valid     <= 1'b0;
      bundle.rd_we     <= 1'b0;
      bundle.is_branch <= 1'b0;
      bundle.is_jal    <= 1'b0;
      bundle.is_jalr   <= 1'b0;
    end else begin
      bundle.valid     <= valid_i;
      bundle.rd_we     <= valid_i & writes & (rd != '0);
      bundle.is_branch <= (opcode == OPC_BRANCH) & br_ok;
      bundle.is_jal    <= (opcode == OPC_JAL);
      bundle.is_jalr   <= (opcode == OPC_JALR);
    end
  end

  // payload
  always_ff @(posedge clk) begin
    bundle.pc           <= pc_i;
    bundle.rs1_val      <= rs1_data_i;
    bundle.rs2_val      <= rs2_data_i;
    bundle.imm          <= imm;
    bundle.alu_ctrl     <= alu_ctrl;
    bundle.use_imm      <= use_imm;
    bundle.use_pc       <= use_pc;
    bundle.rd           <= rd;
    bundle.res_sel_link <= (opcode == OPC_JAL) | (opcode == OPC_JALR);
    bundle.res_sel_imm  <= (opcode == OPC_LUI);
    bundle.funct3       <= funct3;
  end

endmodule

// ==== rtl/alu_unit.sv ====
`timescale 1ns/1ps

module alu_unit (
  exec_bundle_if.consumer       bundle,
  output exec_types_pkg::xlen_t result_o
);
  import exec_types_pkg::*;
  import rv32i_isa_pkg::*;

  localparam int unsigned SHAMT_W = $clog2(XLEN);

  xlen_t              op_a;
  xlen_t              op_b;
  logic [SHAMT_W-1:0] shamt;

  // pc feeds operand a for auipc
  assign op_a  = bundle.use_pc ? bundle.pc : bundle.rs1_val;
  assign op_b  = bundle.use_imm ? bundle.imm : bundle.rs2_val;
  assign shamt = op_b[SHAMT_W-1:0];

  always_comb begin
    case (bundle.alu_ctrl)
      ALU_ADD:  result_o = op_a + op_b;
      ALU_SUB:  result_o = op_a - op_b;
      ALU_SLL:  result_o = op_a << shamt;
      ALU_SLT:  result_o = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_SLTU: result_o = {{(XLEN-1){1'b0}}, op_a < op_b};
      ALU_XOR:  result_o = op_a ^ op_b;
      ALU_SRL:  result_o = op_a >> shamt;
      ALU_SRA:  result_o = xlen_t'($signed(op_a) >>> shamt);
      ALU_OR:   result_o = op_a | op_b;
      ALU_AND:  result_o = op_a & op_b;
      default:  result_o = '0;
    endcase
  end

endmodule

// ==== rtl/branch_unit.sv ====
`timescale 1ns/1ps

module branch_unit (
  exec_bundle_if.consumer       bundle,
  output logic                  taken_o,
  output exec_types_pkg::xlen_t target_o
);
  import exec_types_pkg::*;
  import rv32i_isa_pkg::*;

  logic  cond;
  xlen_t base;
  xlen_t sum;

  always_comb begin
    case (bundle.funct3)
      F3_BEQ:  cond = (bundle.rs1_val == bundle.rs2_val);
      F3_BNE:  cond = (bundle.rs1_val != bundle.rs2_val);
      F3_BLT:  cond = ($signed(bundle.rs1_val) < $signed(bundle.rs2_val));
      F3_BGE:  cond = ($signed(bundle.rs1_val) >= $signed(bundle.rs2_val));
      F3_BLTU: cond = (bundle.rs1_val < bundle.rs2_val);
      F3_BGEU: cond = (bundle.rs1_val >= bundle.rs2_val);
      default: cond = 1'b0;
    endcase
  end

  // jumps always taken
  assign taken_o = bundle.is_jal | bundle.is_jalr | (bundle.is_branch & cond);

  // jalr is register relative, everything else pc relative
  assign base     = bundle.is_jalr ? bundle.rs1_val : bundle.pc;
  assign sum      = base + bundle.imm;
  assign target_o = {sum[XLEN-1:1], sum[0] & ~bundle.is_jalr};

endmodule

// ==== rtl/result_select.sv ====
`timescale 1ns/1ps

module result_select (
  input  logic                      clk,
  input  logic                      arst_n_i,
  exec_bundle_if.consumer           bundle,
  input  exec_types_pkg::xlen_t     alu_result_i,
  input  logic                      taken_i,
  input  exec_types_pkg::xlen_t     target_i,
  output logic                      valid_o,
  output exec_types_pkg::reg_addr_t rd_addr_o,
  output logic                      rd_we_o,
  output exec_types_pkg::xlen_t     rd_data_o,
  output logic                      redirect_o,
  output exec_types_pkg::xlen_t     target_pc_o
);
  import exec_types_pkg::*;

  xlen_t wdata;
  logic  redirect;

  // link address for jumps, imm for lui
  always_comb begin
    if (bundle.res_sel_link) begin
      wdata = bundle.pc + PC_STEP;
    end else if (bundle.res_sel_imm) begin
      wdata = bundle.imm;
    end else begin
      wdata = alu_result_i;
    end
  end

  assign redirect = bundle.valid & taken_i;

  // ====================
  // write-back register
  // ====================
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_o    <= 1'b0;
      rd_we_o    <= 1'b0;
      redirect_o <= 1'b0;
    end else begin
      valid_o    <= bundle.valid;
      rd_we_o    <= bundle.rd_we;
      redirect_o <= redirect;
    end
  end

  always_ff @(posedge clk) begin
    rd_addr_o <= bundle.rd;
    rd_data_o <= wdata;
    // target only meaningful with redirect
    if (redirect) begin
      target_pc_o <= target_i;
    end
  end

endmodule

// ==== rtl/exec_core.sv ====
`timescale 1ns/1ps

module exec_core (
  input  logic                      clk,
  input  logic                      arst_n_i,
  input  logic                      valid_i,
  input  exec_types_pkg::instr_t    instr_i,
  input  exec_types_pkg::xlen_t     pc_i,
  input  exec_types_pkg::xlen_t     rs1_data_i,
  input  exec_types_pkg::xlen_t     rs2_data_i,
  output logic                      valid_o,
  output exec_types_pkg::reg_addr_t rd_addr_o,
  output logic                      rd_we_o,
  output exec_types_pkg::xlen_t     rd_data_o,
  output logic                      redirect_o,
  output exec_types_pkg::xlen_t     target_pc_o
);
  import exec_types_pkg::*;

  xlen_t alu_result;
  logic  br_taken;
  xlen_t br_target;

  // decoded instruction between decode and execute
  exec_bundle_if i_bundle ();

  instr_decode i_instr_decode (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .valid_i    (valid_i),
    .instr_i    (instr_i),
    .pc_i       (pc_i),
    .rs1_data_i (rs1_data_i),
    .rs2_data_i (rs2_data_i),
    .bundle     (i_bundle.producer)
  );

  alu_unit i_alu_unit (
    .bundle   (i_bundle.consumer),
    .result_o (alu_result)
  );

  branch_unit i_branch_unit (
    .bundle   (i_bundle.consumer),
    .taken_o  (br_taken),
    .target_o (br_target)
  );

  result_select i_result_select (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .bundle       (i_bundle.consumer),
    .alu_result_i (alu_result),
    .taken_i      (br_taken),
    .target_i     (br_target),
    .valid_o      (valid_o),
    .rd_addr_o    (rd_addr_o),
    .rd_we_o      (rd_we_o),
    .rd_data_o    (rd_data_o),
    .redirect_o   (redirect_o),
    .target_pc_o  (target_pc_o)
  );

endmodule

// ==== tb/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen #(
  parameter int unsigned HALF_PERIOD_NS = 50,
  parameter int unsigned RESET_CYCLES   = 3
) (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
  end

  // release on a falling edge, clear of the capture edge
  initial begin
    arst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk_o);
    arst_n_o = 1'b1;
  end

endmodule

// ==== tb/exec_core_assertions.sv ====
`timescale 1ns/1ps

module exec_core_assertions (
  input logic                      clk,
  input logic                      arst_n_i,
  input logic                      valid_i,
  input logic                      valid_o,
  input exec_types_pkg::reg_addr_t rd_addr_o,
  input logic                      rd_we_o,
  input logic                      redirect_o,
  input exec_types_pkg::xlen_t     target_pc_o
);

  // redirect only with a result
  redirect_has_valid: assert property (
    @(posedge clk) disable iff (!arst_n_i) redirect_o |-> valid_o
  ) else $error("redirect_o high while valid_o is low");

  // no writes to x0
  write_has_valid_rd: assert property (
    @(posedge clk) disable iff (!arst_n_i) rd_we_o |-> (valid_o && (rd_addr_o != '0))
  ) else $error("rd_we_o high without valid_o or with rd x0");

  // fixed two stage latency
  // an instruction seen while in reset is dropped
  valid_latency: assert property (
    @(posedge clk) disable iff (!arst_n_i)
      valid_o == ($past(valid_i, 2) && $past(arst_n_i, 2))
  ) else $error("valid_o does not follow valid_i by two cycles");

  redirect_target_aligned: assert property (
    @(posedge clk) disable iff (!arst_n_i) redirect_o |-> (target_pc_o[0] == 1'b0)
  ) else $error("redirect target has bit 0 set");

endmodule

bind exec_core exec_core_assertions i_exec_core_assertions (
  .clk         (clk),
  .arst_n_i    (arst_n_i),
  .valid_i     (valid_i),
  .valid_o     (valid_o),
  .rd_addr_o   (rd_addr_o),
  .rd_we_o     (rd_we_o),
  .redirect_o  (redirect_o),
  .target_pc_o (target_pc_o)
);

// ==== tb/tb_exec_core.sv ====
`timescale 1ns/1ps

module tb_exec_core;
  import exec_types_pkg::*;

  localparam int          NUM_VECTORS     = 22;
  localparam int          WORDS_PER_VEC   = 9;
  localparam int          LATENCY         = 2;
  localparam int          WATCHDOG_CYCLES = 4 * NUM_VECTORS + 20;
  localparam logic [31:0] SEED            = 32'h066e5285;

  logic      clk;
  logic      arst_n;
  logic      in_valid;
  instr_t    in_instr;
  xlen_t     in_pc;
  xlen_t     in_rs1;
  xlen_t     in_rs2;
  logic      out_valid;
  reg_addr_t out_rd_addr;
  logic      out_rd_we;
  xlen_t     out_rd_data;
  logic      out_redirect;
  xlen_t     out_target_pc;

  // instr pc rs1 rs2 rd_we rd rd_data redirect target, one word each
  logic [31:0] vec_mem [0:NUM_VECTORS*WORDS_PER_VEC-1];
  int          pend_idx[$];
  int          pend_cycle[$];

  clock_gen i_clock_gen (
    .clk_o    (clk),
    .arst_n_o (arst_n)
  );

  exec_core i_exec_core (
    .clk         (clk),
    .arst_n_i    (arst_n),
    .valid_i     (in_valid),
    .instr_i     (in_instr),
    .pc_i        (in_pc),
    .rs1_data_i  (in_rs1),
    .rs2_data_i  (in_rs2),
    .valid_o     (out_valid),
    .rd_addr_o   (out_rd_addr),
    .rd_we_o     (out_rd_we),
    .rd_data_o   (out_rd_data),
    .redirect_o  (out_redirect),
    .target_pc_o (out_target_pc)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
      $display("Simulation finished: FAIL");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  // ====================
  // result comparison
  // ====================
  task automatic check_result(input int idx, input int issue_cycle, input int now_cycle);
    string name;
    int    base;
    base = idx * WORDS_PER_VEC;
    name = $sformatf("vector %0d", idx);
    check_value({name, " latency"}, 32'(LATENCY), 32'(now_cycle - issue_cycle));
    check_value({name, " rd_we"}, vec_mem[base+4], 32'(out_rd_we));
    check_value({name, " redirect"}, vec_mem[base+7], 32'(out_redirect));
    // rd and data only matter for a write
    if (vec_mem[base+4][0]) begin
      check_value({name, " rd"}, vec_mem[base+5], 32'(out_rd_addr));
      check_value({name, " rd_data"}, vec_mem[base+6], out_rd_data);
    end
    if (vec_mem[base+7][0]) begin
      check_value({name, " target"}, vec_mem[base+8], out_target_pc);
    end
  endtask

  // ====================
  // stimulus and checking
  // ====================
  initial begin : stimulus
    logic [31:0] rnd;
    int          cycle;
    int          next_vec;
    int          base;
    bit          was_idle;
    $readmemh("tb/exec_core_testdata.hex", vec_mem);
    // a valid instruction held during reset must never come out
    in_valid = 1'b1;
    in_instr = vec_mem[0];
    in_pc    = vec_mem[1];
    in_rs1   = vec_mem[2];
    in_rs2   = vec_mem[3];
    rnd      = SEED;
    cycle    = 0;
    next_vec = 0;
    was_idle = 1'b0;

    // control outputs held low in reset
    repeat (2) begin
      @(negedge clk);
      check_value("reset valid_o", 32'h0, 32'(out_valid));
      check_value("reset rd_we_o", 32'h0, 32'(out_rd_we));
      check_value("reset redirect_o", 32'h0, 32'(out_redirect));
    end
    wait (arst_n === 1'b1);
    in_valid = 1'b0;

    while (next_vec < NUM_VECTORS || pend_idx.size() > 0) begin
      @(negedge clk);
      cycle++;
      // outputs settled at the last rising edge and are checked first
      if (out_valid) begin
        if (pend_idx.size() == 0) begin
          $display("valid_o went high with no instruction in flight");
          $display("Simulation finished: FAIL");
          $fatal(1, "unexpected result");
        end else begin
          check_result(pend_idx.pop_front(), pend_cycle.pop_front(), cycle);
        end
      end
      if (next_vec < NUM_VECTORS) begin
        rnd = xorshift32(rnd);
        if (rnd[1:0] == 2'b00 && !was_idle) begin
          // idle slot with junk payload
          in_valid = 1'b0;
          in_instr = rnd;
          in_pc    = ~rnd;
          in_rs1   = rnd;
          in_rs2   = ~rnd;
          was_idle = 1'b1;
        end else begin
          base     = next_vec * WORDS_PER_VEC;
          in_valid = 1'b1;
          in_instr = vec_mem[base];
          in_pc    = vec_mem[base+1];
          in_rs1   = vec_mem[base+2];
          in_rs2   = vec_mem[base+3];
          pend_idx.push_back(next_vec);
          pend_cycle.push_back(cycle);
          next_vec++;
          was_idle = 1'b0;
        end
      end else begin
        in_valid = 1'b0;
      end
    end

    $display("Simulation finished: PASS");
    $finish;
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles with results still missing",
             WATCHDOG_CYCLES);
    $display("Simulation finished: FAIL");
    $fatal(1, "timeout");
  end

endmodule

// ==== verilog.f ====
rtl/rv32i_isa_pkg.sv
rtl/exec_types_pkg.sv
rtl/exec_bundle_if.sv
rtl/instr_decode.sv
rtl/alu_unit.sv
rtl/branch_unit.sv
rtl/result_select.sv
rtl/exec_core.sv
tb/clock_gen.sv
tb/exec_core_assertions.sv
tb/tb_exec_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_exec_core
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation finished: PASS
VFLAGS    ?= --binary --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb/exec_core_testdata.hex ====
// instr pc rs1 rs2, then expected rd_we rd rd_data redirect target_pc
// rd and rd_data checked only when rd_we is 1, target_pc only when redirect is 1
002081B3 00000100 00000005 00000007 1 03 0000000C 0 00000000
40208233 00000104 00000003 0000000A 1 04 FFFFFFF9 0 00000000
002092B3 00000108 00000003 00000024 1 05 00000030 0 00000000
0020A333 0000010C FFFFFFFE 00000001 1 06 00000001 0 00000000
0020B3B3 00000110 FFFFFFFE 00000001 1 07 00000000 0 00000000
0020C433 00000114 F0F0F0F0 0FF00FF0 1 08 FF00FF00 0 00000000
0020D4B3 00000118 80000000 00000004 1 09 08000000 0 00000000
4020D533 0000011C 80000000 00000004 1 0A F8000000 0 00000000
0020E5B3 00000120 00FF0000 000000FF 1 0B 00FF00FF 0 00000000
0020F633 00000124 12345678 0000FFFF 1 0C 00005678 0 00000000
4030D713 00000128 80000010 00000000 1 0E F0000002 0 00000000
12345837 0000012C A5A5A5A5 5A5A5A5A 1 10 12345000 0 00000000
00001897 00000130 A5A5A5A5 5A5A5A5A 1 11 00001130 0 00000000
FFF08013 00000134 00000010 00000000 0 00 00000000 0 00000000
008000EF 00000138 00000000 00000000 1 01 0000013C 1 00000140
003082E7 0000013C 00001000 00000000 1 05 00000140 1 00001002
00208863 00000140 00000055 00000055 0 00 00000000 1 00000150
FE209CE3 00000144 00000001 00000002 0 00 00000000 1 0000013C
0020C863 00000148 FFFFFFFF 00000001 0 00 00000000 1 00000158
0020D863 0000014C FFFFFFFF 00000001 0 00 00000000 0 00000000
0020E863 00000150 FFFFFFFF 00000001 0 00 00000000 0 00000000
0020F863 00000154 FFFFFFFF 00000001 0 00 00000000 1 00000164
